// File: list.f
+incdir+hdl
hdl/load_unit_pkg.sv
hdl/load_req_fsm.sv
hdl/load_tag_stage.sv
hdl/load_align.sv
hdl/load_unit_top.sv
tb/cache_tlb_model.sv
tb/tb_load_unit.sv

// File: tb/tb_load_unit.sv
// ------------------------------
// directed testbench for the load path that issues loads and checks every retired result
// ------------------------------
`include "load_unit_settings.svh"

module tb_load_unit import load_unit_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    // the watchdog allows 40 cycles for each load issued over all tests
    localparam int NUM_LOADS    = 39;

    logic                clk_i;
    logic                rst_ni;
    load_req_t           load_req;
    logic                valid;
    logic                flush;
    logic                pop_ld;
    logic [11:0]         page_offset;
    logic                page_offset_matches;
    logic                translation_req;
    logic [`LU_VLEN-1:0] vaddr;
    logic                dtlb_hit;
    logic [`LU_PLEN-1:0] paddr;
    dc_req_t             dc_req;
    dc_rsp_t             dc_rsp;
    logic                valid_out;
    logic [`LU_TID_W-1:0] trans_id;
    logic [`LU_XLEN-1:0] result;
    int                  gnt_delay;
    int                  miss_cycles;
    int                  pops_seen;
    logic [`LU_TAG_W-1:0] exp_tag;

    // results and ids still owed by the DUT with the oldest first
    logic [`LU_XLEN-1:0]  exp_result_q [$];
    logic [`LU_TID_W-1:0] exp_id_q [$];

    load_unit_top i_load_unit_top (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .load_req_i            (load_req),
        .valid_i               (valid),
        .flush_i               (flush),
        .pop_ld_o              (pop_ld),
        .page_offset_o         (page_offset),
        .page_offset_matches_i (page_offset_matches),
        .translation_req_o     (translation_req),
        .vaddr_o               (vaddr),
        .dtlb_hit_i            (dtlb_hit),
        .paddr_i               (paddr),
        .dc_req_o              (dc_req),
        .dc_rsp_i              (dc_rsp),
        .valid_o               (valid_out),
        .trans_id_o            (trans_id),
        .result_o              (result)
    );

    cache_tlb_model i_cache (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .gnt_delay_i       (gnt_delay),
        .miss_cycles_i     (miss_cycles),
        .dc_req_i          (dc_req),
        .dc_rsp_o          (dc_rsp),
        .translation_req_i (translation_req),
        .vaddr_i           (vaddr),
        .dtlb_hit_o        (dtlb_hit),
        .paddr_o           (paddr)
    );

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    function automatic int op_bytes(input load_op_e op);
        case (op)
            LD:      return 8;
            LW, LWU: return 4;
            LH, LHU: return 2;
            default: return 1;
        endcase
    endfunction

    // shift the field down to bit 0, then extend with its own top bit or with zeros
    function automatic logic [63:0] expected_result(input logic [63:0] word,
                                                    input logic [2:0] off, input load_op_e op);
        logic [63:0] sh;
        sh = word >> (8 * off);
        case (op)
            LB:      return {{56{sh[7]}}, sh[7:0]};
            LBU:     return {56'b0, sh[7:0]};
            LH:      return {{48{sh[15]}}, sh[15:0]};
            LHU:     return {48'b0, sh[15:0]};
            LW:      return {{32{sh[31]}}, sh[31:0]};
            LWU:     return {32'b0, sh[31:0]};
            default: return word;
        endcase
    endfunction

    // physical tag under the fixed page mapping of the cache model
    function automatic logic [`LU_TAG_W-1:0] expected_tag(input logic [`LU_VLEN-1:0] va);
        return {17'h0_1c3a, va[38:12] ^ 27'h2a5_5a5a};
    endfunction

    function automatic load_req_t make_req(input logic [8:0] word_idx, input logic [2:0] off,
                                           input load_op_e op, input logic [2:0] id);
        load_req_t req;
        req.vaddr    = {27'(word_idx * 27'h1_3579), word_idx, off};
        req.be       = 8'(((16'd1 << op_bytes(op)) - 16'd1) << off);
        req.trans_id = id;
        req.op       = op;
        return req;
    endfunction

    task automatic start_load(input load_req_t req);
        @(posedge clk_i);
        #1;
        load_req = req;
        valid    = 1'b1;
    endtask

    task automatic drop_valid();
        @(posedge clk_i);
        #1;
        valid = 1'b0;
    endtask

    task automatic record_pop();
        exp_result_q.push_back(expected_result(i_cache.mem[load_req.vaddr[11:3]],
                                               load_req.vaddr[2:0], load_req.op));
        exp_id_q.push_back(load_req.trans_id);
    endtask

    // returns at the sampling point of the pop cycle
    task automatic wait_pop(input bit expect_data);
        @(negedge clk_i);
        while (!pop_ld) @(negedge clk_i);
        if (expect_data) record_pop();
    endtask

    // extra cycles after the last result let a stray valid_o show up
    task automatic drain();
        while (exp_result_q.size() != 0) @(negedge clk_i);
        repeat (3) @(negedge clk_i);
    endtask

    task automatic set_model(input int gnt, input int miss);
        @(posedge clk_i);
        #1;
        gnt_delay   = gnt;
        miss_cycles = miss;
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------

    // every operator at every offset it may legally use
    task automatic test_all_ops();
        load_op_e op;
        int n;
        n = 0;
        for (int k = 0; k < 7; k++) begin
            op = load_op_e'(k);
            for (int off = 0; off < 8; off += op_bytes(op)) begin
                start_load(make_req(9'(n * 37 + 5), 3'(off), op, 3'(n)));
                wait_pop(1'b1);
                drop_valid();
                drain();
                n++;
            end
        end
    endtask

    task automatic test_grant_delay();
        int held;
        set_model(5, 0);
        for (int i = 0; i < 2; i++) begin
            start_load(make_req(9'(100 + i * 211), 3'(i * 4), LWU, 3'(i + 2)));
            held = 0;
            @(negedge clk_i);
            while (!dc_rsp.data_gnt) begin
                check("data_req", dc_req.data_req, 1'b1);
                check("translation_req_o", translation_req, 1'b1);
                held++;
                @(negedge clk_i);
            end
            check("cycles waiting for data_gnt", 64'(held), 64'd5);
            check("pop_ld_o", pop_ld, 1'b1);
            record_pop();
            drop_valid();
            drain();
        end
        set_model(0, 0);
    endtask

    // the miss is seen at the grant, so the request is aborted and retried
    task automatic test_tlb_miss();
        set_model(0, 3);
        start_load(make_req(9'h1a3, 3'd4, LW, 3'd5));
        @(negedge clk_i);
        while (!dc_req.kill_req) begin
            check("pop_ld_o", pop_ld, 1'b0);
            @(negedge clk_i);
        end
        check("tag_valid", dc_req.tag_valid, 1'b1);
        @(negedge clk_i);
        while (!dtlb_hit) begin
            check("translation_req_o", translation_req, 1'b1);
            @(negedge clk_i);
        end
        wait_pop(1'b1);
        drop_valid();
        drain();
        set_model(0, 0);
    endtask

    // the match is registered inside the DUT, so it is raised a cycle early
    task automatic test_offset_stall();
        @(posedge clk_i);
        #1;
        page_offset_matches = 1'b1;
        start_load(make_req(9'h07c, 3'd6, LH, 3'd7));
        repeat (4) begin
            @(negedge clk_i);
            check("data_req", dc_req.data_req, 1'b0);
            check("pop_ld_o", pop_ld, 1'b0);
            check("page_offset_o", page_offset, load_req.vaddr[11:0]);
        end
        @(posedge clk_i);
        #1;
        page_offset_matches = 1'b0;
        wait_pop(1'b1);
        drop_valid();
        drain();
    endtask

    // flush lands in the tag cycle, before any data can come back
    task automatic test_flush();
        start_load(make_req(9'h0f7, 3'd2, LH, 3'd6));
        wait_pop(1'b0);
        @(posedge clk_i);
        #1;
        valid = 1'b0;
        flush = 1'b1;
        @(negedge clk_i);
        check("tag_valid", dc_req.tag_valid, 1'b1);
        @(posedge clk_i);
        #1;
        flush = 1'b0;
        @(negedge clk_i);
        check("kill_req", dc_req.kill_req, 1'b1);
        // the retire monitor fails the run if the killed load still retires
        repeat (6) @(negedge clk_i);
        start_load(make_req(9'h0f8, 3'd1, LBU, 3'd0));
        wait_pop(1'b1);
        drop_valid();
        drain();
    endtask

    task automatic test_back_to_back();
        load_op_e ops [4];
        int offs [4];
        int pops_before;
        ops = '{LD, LW, LHU, LB};
        offs = '{0, 4, 6, 3};
        pops_before = pops_seen;
        for (int i = 0; i < 4; i++) begin
            start_load(make_req(9'(i * 61 + 3), 3'(offs[i]), ops[i], 3'(i + 1)));
            wait_pop(1'b1);
        end
        drop_valid();
        drain();
        check("number of pops", 64'(pops_seen - pops_before), 64'd4);
    endtask

    // ------------------------------
    // clock, retire monitor, watchdog, sequence
    // ------------------------------
    initial begin : p_clock
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // results must come back in issue order with the id of the popped load
    always @(negedge clk_i) begin : p_retire
        if (rst_ni && pop_ld) pops_seen++;
        if (rst_ni && valid_out) begin
            if (exp_result_q.size() == 0) begin
                fail_run("valid_o was raised while no load was waiting for data");
            end else begin
                check("result_o", result, exp_result_q.pop_front());
                check("trans_id_o", trans_id, exp_id_q.pop_front());
            end
        end
    end

    // the request fields belong to the popped load and its physical tag follows a cycle later
    always @(negedge clk_i) begin : p_request
        if (rst_ni && dc_req.tag_valid && !dc_req.kill_req) begin
            check("address_tag", dc_req.address_tag, exp_tag);
        end
        if (rst_ni && pop_ld) begin
            check("vaddr_o", vaddr, load_req.vaddr);
            check("page_offset_o", page_offset, load_req.vaddr[11:0]);
            check("address_index", dc_req.address_index, load_req.vaddr[11:0]);
            check("data_be", dc_req.data_be, load_req.be);
            check("data_size", dc_req.data_size, $clog2(op_bytes(load_req.op)));
            exp_tag = expected_tag(load_req.vaddr);
        end
    end

    initial begin : p_watchdog
        repeat (RESET_CYCLES + NUM_LOADS * 40) @(posedge clk_i);
        fail_run("the tests did not finish within the cycle limit");
    end

    initial begin : p_main
        load_req            = '0;
        valid               = 1'b0;
        flush               = 1'b0;
        page_offset_matches = 1'b0;
        gnt_delay           = 0;
        miss_cycles         = 0;
        pops_seen           = 0;
        rst_ni              = 1'b0;
        repeat (RESET_CYCLES - 1) @(posedge clk_i);
        @(negedge clk_i);
        check("outputs in reset", {pop_ld, dc_req.data_req, dc_req.tag_valid,
                                   dc_req.kill_req, translation_req, valid_out}, '0);
        @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        test_all_ops();
        test_grant_delay();
        test_tlb_miss();
        test_offset_stall();
        test_flush();
        test_back_to_back();
        $display("sim passed");
        $finish;
    end

endmodule

// File: tb/cache_tlb_model.sv
// ------------------------------
// behavioral data cache and TLB for the load path testbench
// grant delay and miss count are set by the tests and the return delay comes from an LFSR
// ------------------------------
`include "load_unit_settings.svh"

module cache_tlb_model import load_unit_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  int                  gnt_delay_i,
    input  int                  miss_cycles_i,
    input  dc_req_t             dc_req_i,
    output dc_rsp_t             dc_rsp_o,
    input  logic                translation_req_i,
    input  logic [`LU_VLEN-1:0] vaddr_i,
    output logic                dtlb_hit_o,
    output logic [`LU_PLEN-1:0] paddr_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // the cache holds one word per index and the testbench reads them for its expected values
    logic [`LU_XLEN-1:0] mem [512];
    logic [`LU_XLEN-1:0] rdata_q;
    logic [`LU_PLEN-1:0] paddr_q;
    logic [31:0]         lfsr_q;
    logic [31:0]         lfsr_next;
    logic                busy_q;
    logic                pending_q;
    logic [1:0]          ret_cnt_q;
    int                  gnt_cnt_q;
    int                  miss_cnt_q;

    // one Galois step that hands out the bit shifted out at s[0]
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // each 16-bit slice mixes the whole word index in a different way
    initial begin : p_fill
        for (int a = 0; a < 512; a++) begin
            mem[a] = {16'(a * 40503), 16'(a ^ 50085), 16'(a * 3869 + 33008), 16'(~a * 19743)};
        end
    end

    assign lfsr_next  = lfsr_step(lfsr_q);
    // the entry fills once the request was seen for miss_cycles_i cycles in a row
    assign dtlb_hit_o = translation_req_i && (miss_cnt_q >= miss_cycles_i);
    // the lookup is registered, so the physical address belongs to last cycle's vaddr
    assign paddr_o    = paddr_q;

    always_comb begin : p_rsp
        dc_rsp_o             = '0;
        // no new grant while an earlier read has not returned or been killed
        dc_rsp_o.data_gnt    = dc_req_i.data_req && !busy_q && (gnt_cnt_q >= gnt_delay_i);
        dc_rsp_o.data_rvalid = pending_q && (ret_cnt_q == 2'd0);
        if (pending_q && (ret_cnt_q == 2'd0)) begin
            dc_rsp_o.data_rdata.word = rdata_q;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
        if (!rst_ni) begin
            rdata_q    <= '0;
            paddr_q    <= '0;
            lfsr_q     <= 32'h4f0a_ee14;
            busy_q     <= 1'b0;
            pending_q  <= 1'b0;
            ret_cnt_q  <= 2'd0;
            gnt_cnt_q  <= 0;
            miss_cnt_q <= 0;
        end else begin
            // fixed page mapping with the tag left uncompared by this cache
            paddr_q <= {17'h0_1c3a, vaddr_i[38:12] ^ 27'h2a5_5a5a, vaddr_i[11:0]};
            // counts the cycles a request has waited for its grant
            if (dc_req_i.data_req && !dc_rsp_o.data_gnt) begin
                gnt_cnt_q <= gnt_cnt_q + 1;
            end else begin
                gnt_cnt_q <= 0;
            end
            // a dropped translation request restarts the miss count
            if (translation_req_i && !dtlb_hit_o) begin
                miss_cnt_q <= miss_cnt_q + 1;
            end else if (!translation_req_i) begin
                miss_cnt_q <= 0;
            end
            if (dc_rsp_o.data_gnt) begin
                busy_q  <= 1'b1;
                rdata_q <= mem[dc_req_i.address_index[11:3]];
            end
            // a kill drops the read whether or not its tag was already taken
            if (dc_req_i.tag_valid && dc_req_i.kill_req) begin
                busy_q    <= 1'b0;
                pending_q <= 1'b0;
            end else if (dc_req_i.tag_valid && busy_q) begin
                // two LFSR bits give a return delay of 1 to 3 cycles
                pending_q <= 1'b1;
                ret_cnt_q <= 2'(lfsr_q[0]) + 2'(lfsr_next[0]);
                lfsr_q    <= lfsr_step(lfsr_next);
            end else if (pending_q) begin
                if (ret_cnt_q == 2'd0) begin
                    pending_q <= 1'b0;
                    busy_q    <= 1'b0;
                end else begin
                    ret_cnt_q <= ret_cnt_q - 2'd1;
                end
            end
        end
    end

endmodule

// File: hdl/load_unit_top.sv
// ------------------------------
// load path of the load/store unit, connects issue queue, TLB and data cache
// request, tag and align stages are wired here
// ------------------------------
`include "load_unit_settings.svh"

module load_unit_top import load_unit_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // issue queue
    input  load_req_t             load_req_i,
    input  logic                  valid_i,
    input  logic                  flush_i,
    output logic                  pop_ld_o,
    // store offset checker
    output logic [11:0]           page_offset_o,
    input  logic                  page_offset_matches_i,
    // address translation
    output logic                  translation_req_o,
    output logic [`LU_VLEN-1:0]   vaddr_o,
    input  logic                  dtlb_hit_i,
    input  logic [`LU_PLEN-1:0]   paddr_i,
    // data cache
    output dc_req_t               dc_req_o,
    input  dc_rsp_t               dc_rsp_i,
    // retire port
    output logic                  valid_o,
    output logic [`LU_TID_W-1:0]  trans_id_o,
    output logic [`LU_XLEN-1:0]   result_o
);

    logic      capture;
    tag_info_t tag_info;

    // the virtual address goes out untouched, the checker only needs the page offset
    assign vaddr_o       = load_req_i.vaddr;
    assign page_offset_o = load_req_i.vaddr[11:0];

    // ------------------------------
    // cache request fields
    // ------------------------------

    // index is not translated, it lies fully inside the page offset
    assign dc_req_o.address_index = load_req_i.vaddr[`LU_INDEX_W-1:0];
    // the tag is sampled by the cache only in the tag_valid cycle
    assign dc_req_o.address_tag   = paddr_i[`LU_TAG_W+`LU_INDEX_W-1:`LU_INDEX_W];
    assign dc_req_o.data_be       = load_req_i.be;
    assign dc_req_o.data_size     = lu_data_size(load_req_i.op);

    load_req_fsm i_load_req_fsm (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .valid_i               (valid_i),
        .flush_i               (flush_i),
        .pop_ld_o              (pop_ld_o),
        .page_offset_matches_i (page_offset_matches_i),
        .dtlb_hit_i            (dtlb_hit_i),
        .translation_req_o     (translation_req_o),
        .data_gnt_i            (dc_rsp_i.data_gnt),
        .data_rvalid_i         (dc_rsp_i.data_rvalid),
        .data_req_o            (dc_req_o.data_req),
        .tag_valid_o           (dc_req_o.tag_valid),
        .kill_req_o            (dc_req_o.kill_req),
        .capture_o             (capture),
        .valid_o               (valid_o)
    );

    load_tag_stage i_load_tag_stage (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .capture_i  (capture),
        .load_req_i (load_req_i),
        .tag_o      (tag_info)
    );

    load_align i_load_align (
        .tag_i    (tag_info),
        .rdata_i  (dc_rsp_i.data_rdata),
        .result_o (result_o)
    );

    // the id retires together with the data of the load held in the tag stage
    assign trans_id_o = tag_info.trans_id;

endmodule

// File: hdl/load_align.sv
// ------------------------------
// align stage, moves the loaded field to bit 0 and extends it to a full word
// purely combinational on the returned data
// ------------------------------
`include "load_unit_settings.svh"

module load_align import load_unit_pkg::*; (
    input  tag_info_t           tag_i,
    input  rdata_u              rdata_i,
    output logic [`LU_XLEN-1:0] result_o
);

    logic [`LU_XLEN-1:0] shifted;
    logic                sign_bit;

    // ------------------------------
    // shift and sign select
    // ------------------------------

    // byte offset times eight, the field then starts at bit 0
    assign shifted = rdata_i.word >> {tag_i.offset, 3'b000};

    // sign comes straight from the unshifted byte lane, in parallel to the shifter
    // unsigned loads pull it to zero
    assign sign_bit = tag_i.is_signed & rdata_i.lanes[tag_i.sign_lane][7];

    // ------------------------------
    // result mux
    // ------------------------------
    always_comb begin : p_result
        case (tag_i.op)
            LW, LWU: begin
                result_o = {{(`LU_XLEN - 32){sign_bit}}, shifted[31:0]};
            end
            LH, LHU: begin
                result_o = {{(`LU_XLEN - 16){sign_bit}}, shifted[15:0]};
            end
            LB, LBU: begin
                result_o = {{(`LU_XLEN - 8){sign_bit}}, shifted[7:0]};
            end
            // a doubleword is always aligned and passes unchanged
            default: begin
                result_o = shifted;
            end
        endcase
    end

endmodule

// File: hdl/load_tag_stage.sv
// ------------------------------
// tag stage, keeps the popped load's id, offset and operator for the align stage
// ------------------------------
module load_tag_stage import load_unit_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      capture_i,
    input  load_req_t load_req_i,
    output tag_info_t tag_o
);

    tag_info_t tag_d, tag_q;

    // ------------------------------
    // decode ahead of the data return
    // ------------------------------
    always_comb begin : p_decode
        tag_d.trans_id  = load_req_i.trans_id;
        tag_d.offset    = load_req_i.vaddr[2:0];
        tag_d.op        = load_req_i.op;

        // only these three extend with the top bit of the loaded field
        tag_d.is_signed = load_req_i.op inside {LB, LH, LW};

        // byte lane that holds the most significant byte of the field
        // the lane index wraps, which only happens on misaligned accesses
        case (load_req_i.op)
            LW, LWU:  tag_d.sign_lane = load_req_i.vaddr[2:0] + 3'd3;
            LH, LHU:  tag_d.sign_lane = load_req_i.vaddr[2:0] + 3'd1;
            default:  tag_d.sign_lane = load_req_i.vaddr[2:0];
        endcase
    end

    // the record changes only when the request stage pops a load
    // at most one load waits for data, so a single entry is enough
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_tag
        if (!rst_ni) begin
            tag_q <= '0;
        end else if (capture_i) begin
            tag_q <= tag_d;
        end
    end

    assign tag_o = tag_q;

endmodule

// File: hdl/load_req_fsm.sv
// ------------------------------
// request stage of the load path, sequences index, translation and tag
// towards the data cache and decides which returned data may retire
// ------------------------------
module load_req_fsm (
    input  logic clk_i,
    input  logic rst_ni,
    // issue side
    input  logic valid_i,
    input  logic flush_i,
    output logic pop_ld_o,
    // store offset checker and translation
    input  logic page_offset_matches_i,
    input  logic dtlb_hit_i,
    output logic translation_req_o,
    // data cache handshake
    input  logic data_gnt_i,
    input  logic data_rvalid_i,
    output logic data_req_o,
    output logic tag_valid_o,
    output logic kill_req_o,
    // towards the tag stage and the retire port
    output logic capture_o,
    output logic valid_o
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_GNT,
        SEND_TAG,
        WAIT_PAGE_OFFSET,
        ABORT,
        WAIT_TRANSLATION,
        WAIT_FLUSH
    } state_e;

    state_e state_d, state_q;

    // the offset compare comes late in the cycle, so the stall uses last cycle's answer
    logic page_offset_matches_q;

    // set in the states that may start a new load
    logic accept_new;

    // ------------------------------
    // next state
    // ------------------------------
    always_comb begin : p_next_state
        state_d           = state_q;
        translation_req_o = 1'b0;
        data_req_o        = 1'b0;
        tag_valid_o       = 1'b0;
        kill_req_o        = 1'b0;
        pop_ld_o          = 1'b0;
        accept_new        = 1'b0;

        case (state_q)
            IDLE: begin
                accept_new = 1'b1;
            end

            // index and tag of the popped load are both with the cache now
            // the next load can start in this same cycle
            SEND_TAG: begin
                tag_valid_o = 1'b1;
                state_d     = IDLE;
                accept_new  = 1'b1;
            end

            // hold the request and the translation until the cache takes the index
            WAIT_GNT: begin
                translation_req_o = 1'b1;
                data_req_o        = 1'b1;
            end

            // a pending store writes to the same page offset, retry once it drained
            WAIT_PAGE_OFFSET: begin
                if (!page_offset_matches_q) begin
                    state_d = WAIT_GNT;
                end
            end

            // translation missed after the grant, so free the cache port with a kill
            ABORT: begin
                kill_req_o  = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = WAIT_TRANSLATION;
            end

            // keep asking until the page table walk has filled the entry
            WAIT_TRANSLATION: begin
                translation_req_o = 1'b1;
                if (dtlb_hit_i) begin
                    state_d = WAIT_GNT;
                end
            end

            // kill whatever is outstanding in the cache and drop its data
            WAIT_FLUSH: begin
                kill_req_o  = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = IDLE;
            end

            default: begin
                state_d = IDLE;
            end
        endcase

        // start a new load, translation is requested before the offset check is known
        if (accept_new && valid_i) begin
            translation_req_o = 1'b1;
            if (page_offset_matches_q) begin
                state_d = WAIT_PAGE_OFFSET;
            end else begin
                data_req_o = 1'b1;
                state_d    = WAIT_GNT;
            end
        end

        // a granted request either sends its tag next cycle or is aborted
        // on a hit the load leaves the issue queue right here
        if (data_req_o && data_gnt_i) begin
            if (dtlb_hit_i) begin
                pop_ld_o = 1'b1;
                state_d  = SEND_TAG;
            end else begin
                state_d = ABORT;
            end
        end

        // flush wins over everything and kills in the following cycle
        if (flush_i) begin
            state_d = WAIT_FLUSH;
        end
    end

    // a load popped during a flush is killed anyway and keeps the old record
    assign capture_o = pop_ld_o && !flush_i;

    // data retires unless it belongs to a request being killed right now
    assign valid_o = data_rvalid_i && (state_q != WAIT_FLUSH) && !kill_req_o;

    // ------------------------------
    // registers
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
        if (!rst_ni) begin
            state_q               <= IDLE;
            page_offset_matches_q <= 1'b0;
        end else begin
            state_q               <= state_d;
            page_offset_matches_q <= page_offset_matches_i;
        end
    end

endmodule

// File: hdl/load_unit_pkg.sv
// ------------------------------
// types of the load path: operator, issue request, cache port, tag record
// ------------------------------
`include "load_unit_settings.svh"

package load_unit_pkg;

    // load operator as decoded by the issue stage
    typedef enum logic [2:0] {
        LB,
        LBU,
        LH,
        LHU,
        LW,
        LWU,
        LD
    } load_op_e;

    // request from the issue queue, held stable until popped
    typedef struct packed {
        logic [`LU_VLEN-1:0]  vaddr;
        logic [7:0]           be;
        logic [`LU_TID_W-1:0] trans_id;
        load_op_e             op;
    } load_req_t;

    // request towards the data cache
    // the index goes out with data_req, the tag follows with tag_valid
    typedef struct packed {
        logic                   data_req;
        logic [`LU_INDEX_W-1:0] address_index;
        logic [`LU_TAG_W-1:0]   address_tag;
        logic                   tag_valid;
        logic                   kill_req;
        logic [7:0]             data_be;
        logic [1:0]             data_size;
    } dc_req_t;

    // the returned word, read whole for the shifter and per byte for sign bits
    typedef union packed {
        logic [`LU_XLEN-1:0] word;
        logic [7:0][7:0]     lanes;
    } rdata_u;

    // response from the data cache
    typedef struct packed {
        logic   data_gnt;
        logic   data_rvalid;
        rdata_u data_rdata;
    } dc_rsp_t;

    // record of the load in flight, kept from pop until its data is back
    // is_signed and sign_lane are decoded early to keep the return path short
    typedef struct packed {
        logic [`LU_TID_W-1:0] trans_id;
        logic [2:0]           offset;
        load_op_e             op;
        logic                 is_signed;
        logic [2:0]           sign_lane;
    } tag_info_t;

    // log2 of the access size in bytes, as the cache expects it
    function automatic logic [1:0] lu_data_size(load_op_e op);
        logic [1:0] size;
        case (op)
            LD:       size = 2'b11;
            LW, LWU:  size = 2'b10;
            LH, LHU:  size = 2'b01;
            default:  size = 2'b00;
        endcase
        return size;
    endfunction

endpackage

// File: hdl/load_unit_settings.svh
// ------------------------------
// widths shared by the load unit RTL and its testbench
// include wherever one of the LU_ macros is needed
// ------------------------------
`ifndef LOAD_UNIT_SETTINGS_SVH
`define LOAD_UNIT_SETTINGS_SVH

// width of one data word returned by the cache
`define LU_XLEN 64

// virtual address width as seen by the issue side
`define LU_VLEN 39

// physical address width delivered by the translation lookaside buffer
`define LU_PLEN 56

// cache geometry: index comes from the untranslated page offset,
// the tag from the physical address above it
`define LU_INDEX_W 12
`define LU_TAG_W 44

// transaction id width, enough for the scoreboard entries of the core
`define LU_TID_W 3

`endif
